//--- project.f
fm_pkg.sv
fm_slot_sequencer.sv
fm_operator.sv
fm_mod_buffer.sv
fm_voice_mixer.sv
fm_synth_top.sv
tb_fm_synth.sv

//--- Makefile
# Verilator build and run of the FM synth testbench
VERILATOR ?= verilator
TOP       ?= tb_fm_synth
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(BIN): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the binary exits non-zero on $fatal, so make reports the failure
test: $(BIN) sine_quarter.mem
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- sine_quarter.mem
// signed 16-bit quarter-wave sine, one hex sample per line, entry j at address j
0192
04B6
07D9
0AFB
0E1C
113A
1455
176E
1A82
1D93
209F
23A6
26A8
29A3
2C99
2F87
326E
354D
3824
3AF2
3DB8
4073
4325
45CD
4869
4AFB
4D81
4FFB
5268
54C9
571D
5964
5B9C
5DC7
5FE3
61F0
63EE
65DD
67BC
698B
6B4A
6CF8
6E96
7022
719D
7307
745F
75A5
76D8
77FA
7909
7A05
7AEE
7BC5
7C88
7D38
7DD5
7E5F
7ED5
7F37
7F86
7FC1
7FE9
7FFD

//--- tb_fm_synth.sv
`timescale 1ns/1ps

module tb_fm_synth;
    import fm_pkg::*;

    // per-slot stimulus patterns
    typedef enum int {
        PAT_ZERO,
        PAT_CARRIER_DC,
        PAT_CARRIER_STEPS,
        PAT_RANDOM,
        PAT_REWRITE_DC,
        PAT_REWRITE_STEPS
    } pattern_e;

    // one table row, expected only applies when closed is set
    typedef struct {
        string    name;
        pattern_e pattern;
        int       frames;
        bit       closed;
        int       expected;
    } case_t;

    logic               clock = 1'b0;
    logic               rst_n = 1'b0;
    logic               run = 1'b0;
    fm_cfg_t            cfg = '0;
    logic signed [15:0] sample;
    logic               sample_ready;

    // reference copy of the quarter-wave table
    logic [15:0] sine_ref [SINE_ENTRIES];

    // slot settings of the current row
    int step_tab [NUM_SLOTS];
    int level_tab [NUM_SLOTS];

    logic [15:0] lfsr_state = 16'd63;

    case_t cases [6];

    // 8 ns period
    always #4 clock = ~clock;

    fm_synth_top u_dut (
        .i_Clock        (clock),
        .i_rst_n        (rst_n),
        .i_run          (run),
        .i_cfg          (cfg),
        .o_sample       (sample),
        .o_sample_ready (sample_ready)
    );

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] cur);
        return cur[0] ? ((cur >> 1) ^ 16'hB400) : (cur >> 1);
    endfunction

    // 16 bits, one lfsr step per bit
    task automatic take_random(output int val);
        logic [15:0] bits;
        bits = '0;
        for (int b = 0; b < 16; b++) begin
            bits = {bits[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        val = int'(bits);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input longint got, input longint exp);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s, got %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // sampled at the falling edge, outputs are settled there
    task automatic wait_sample_ready(input int limit, output int cycles);
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge clock);
            cycles++;
            seen = sample_ready;
        end
        if (!seen) begin
            abort_run($sformatf("timeout, no sample ready pulse within %0d cycles", limit));
        end
    endtask

    task automatic fill_pattern(input pattern_e pat);
        int op;
        int v;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            op = s / NUM_VOICES;
            v  = s % NUM_VOICES;
            step_tab[s]  = 0;
            level_tab[s] = 0;
            case (pat)
                PAT_ZERO: begin
                    // phases run but every level is silent
                    step_tab[s] = (s * 613) & 'hFFFF;
                end
                PAT_CARRIER_DC, PAT_REWRITE_DC: begin
                    if (op == CARRIER_OP) begin
                        level_tab[s] = 'h8000;
                    end
                end
                PAT_CARRIER_STEPS, PAT_REWRITE_STEPS: begin
                    // steps large enough to sweep all four quadrants in 8 frames
                    if (op == CARRIER_OP) begin
                        step_tab[s]  = 'h0400 + v * 'h0D00;
                        level_tab[s] = 'h4000 + v * 'h0800;
                    end
                end
                default: begin
                    take_random(step_tab[s]);
                    take_random(level_tab[s]);
                end
            endcase
            // voice 3 carrier raised to full scale
            if ((pat == PAT_REWRITE_DC || pat == PAT_REWRITE_STEPS) &&
                op == CARRIER_OP && v == 3) begin
                level_tab[s] = 'hFFFF;
            end
        end
    endtask

    task automatic load_slots();
        for (int s = 0; s < NUM_SLOTS; s++) begin
            @(posedge clock);
            cfg <= '{we: 1'b1, slot: 7'(s), step: 16'(step_tab[s]), level: 16'(level_tab[s])};
        end
        @(posedge clock);
        cfg <= '0;
    endtask

    // mixed sample of frame n, straight from the arithmetic rules
    function automatic int model_frame(input int n);
        int     prev_out [NUM_VOICES];
        int     sum;
        int     s;
        int     phase;
        int     eff;
        int     idx;
        int     quad;
        int     j;
        int     sine;
        longint prod;
        sum = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            prev_out[v] = 0;
        end
        for (int op = 0; op < NUM_OPS; op++) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                s     = op * NUM_VOICES + v;
                phase = (n * step_tab[s]) & 'hFFFF;
                // operator 0 is never modulated
                eff   = (op == 0) ? phase : ((phase + (prev_out[v] & 'hFFFF)) & 'hFFFF);
                idx   = eff >> 8;
                quad  = idx >> 6;
                j     = idx & 63;
                if (quad == 1 || quad == 3) begin
                    j = 63 - j;
                end
                sine = int'($signed(sine_ref[j]));
                if (quad >= 2) begin
                    sine = -sine;
                end
                prod = longint'(sine) * longint'(level_tab[s]);
                prev_out[v] = int'(prod >>> 16);
                if (op == CARRIER_OP) begin
                    sum += prev_out[v];
                end
            end
        end
        return sum >>> 4;
    endfunction

    initial begin
        int cycles;
        int expected;
        $readmemh("sine_quarter.mem", sine_ref);
        // carrier dc: (402 * 0x8000) >> 16 = 201 per voice
        // rewrite dc: voice 3 at 0xffff gives 401, (15 * 201 + 401) >> 4 = 213
        cases[0] = '{"levels_zero", PAT_ZERO, 3, 1'b1, 0};
        cases[1] = '{"carrier_dc", PAT_CARRIER_DC, 3, 1'b1, 201};
        cases[2] = '{"carrier_steps", PAT_CARRIER_STEPS, 8, 1'b0, 0};
        cases[3] = '{"random_chain", PAT_RANDOM, 6, 1'b0, 0};
        cases[4] = '{"rewrite_dc", PAT_REWRITE_DC, 3, 1'b1, 213};
        cases[5] = '{"rewrite_steps", PAT_REWRITE_STEPS, 8, 1'b0, 0};

        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        // idle after reset, nothing may come out
        for (int c = 0; c < 150; c++) begin
            @(negedge clock);
            check_value("ready while idle", longint'(sample_ready), 0);
            check_value("sample while idle", longint'(sample), 0);
        end

        for (int r = 0; r < 6; r++) begin
            @(posedge clock);
            run <= 1'b0;
            fill_pattern(cases[r].pattern);
            load_slots();
            @(posedge clock);
            run <= 1'b1;
            for (int f = 0; f < cases[r].frames; f++) begin
                wait_sample_ready(2 * NUM_SLOTS + 16, cycles);
                if (f > 0) begin
                    check_value($sformatf("%s pulse spacing", cases[r].name),
                                longint'(cycles), NUM_SLOTS);
                end
                expected = model_frame(f);
                check_value($sformatf("%s frame %0d", cases[r].name, f),
                            longint'(sample), longint'(expected));
                if (cases[r].closed) begin
                    check_value($sformatf("%s frame %0d closed form", cases[r].name, f),
                                longint'(sample), longint'(cases[r].expected));
                end
            end
            $display("case %s, %0d frames checked", cases[r].name, cases[r].frames);
        end

        @(posedge clock);
        run <= 1'b0;
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- fm_synth_top.sv
`timescale 1ns/1ps

module fm_synth_top (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  logic                i_run,
    input  fm_pkg::fm_cfg_t     i_cfg,
    output logic signed [15:0]  o_sample,
    output logic                o_sample_ready
);
    import fm_pkg::*;

    // sequencer to operator
    fm_slot_t w_slot;

    // operator result to buffer and mixer
    fm_out_t w_out;

    // modulation read path
    logic [VOICE_W-1:0]         w_mod_voice;
    logic signed [SAMPLE_W-1:0] w_mod_sample;

    fm_slot_sequencer u_sequencer (
        .i_Clock (i_Clock),
        .i_rst_n (i_rst_n),
        .i_run   (i_run),
        .i_cfg   (i_cfg),
        .o_slot  (w_slot)
    );

    fm_operator u_operator (
        .i_Clock      (i_Clock),
        .i_rst_n      (i_rst_n),
        .i_slot       (w_slot),
        .o_mod_voice  (w_mod_voice),
        .i_mod_sample (w_mod_sample),
        .o_out        (w_out)
    );

    fm_mod_buffer u_mod_buffer (
        .i_Clock     (i_Clock),
        .i_rst_n     (i_rst_n),
        .i_out       (w_out),
        .i_rd_voice  (w_mod_voice),
        .o_rd_sample (w_mod_sample)
    );

    fm_voice_mixer u_mixer (
        .i_Clock        (i_Clock),
        .i_rst_n        (i_rst_n),
        .i_out          (w_out),
        .o_sample       (o_sample),
        .o_sample_ready (o_sample_ready)
    );

endmodule

//--- fm_voice_mixer.sv
`timescale 1ns/1ps

module fm_voice_mixer (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  fm_pkg::fm_out_t     i_out,
    output logic signed [15:0]  o_sample,
    output logic                o_sample_ready
);
    import fm_pkg::*;

    logic signed [MIX_W-1:0]    r_sum;
    logic signed [MIX_W-1:0]    w_sum_base;
    logic signed [MIX_W-1:0]    w_sum_next;
    logic signed [SAMPLE_W-1:0] w_in_sample;
    logic                       w_carrier;
    logic                       w_first;
    logic                       w_last;

    // only carrier outputs are summed
    assign w_carrier = i_out.valid && (i_out.op == OP_W'(CARRIER_OP));
    assign w_first   = w_carrier && (i_out.voice == '0);
    assign w_last    = w_carrier && (i_out.voice == VOICE_W'(NUM_VOICES - 1));

    assign w_in_sample = i_out.sample;

    // voice 0 opens a frame, so a partial frame left by a stop is dropped
    assign w_sum_base = w_first ? '0 : r_sum;
    assign w_sum_next = w_sum_base + {{(MIX_W-SAMPLE_W){w_in_sample[SAMPLE_W-1]}}, w_in_sample};

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_sum          <= '0;
            o_sample       <= '0;
            o_sample_ready <= 1'b0;
        end else begin
            o_sample_ready <= w_last;
            if (w_last) begin
                // frame complete
                // divide by 16 through the top bits, sample held until next frame
                o_sample <= w_sum_next[MIX_W-1:MIX_SHIFT];
                r_sum    <= '0;
            end else if (w_carrier) begin
                r_sum <= w_sum_next;
            end
        end
    end

    // carriers of voice 15 are a frame apart, so ready is a single pulse
    a_ready_pulse: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        o_sample_ready |=> !o_sample_ready)
        else $error("sample ready held for two cycles");

endmodule

//--- fm_mod_buffer.sv
`timescale 1ns/1ps

module fm_mod_buffer (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  fm_pkg::fm_out_t     i_out,
    input  logic [3:0]          i_rd_voice,
    output logic signed [15:0]  o_rd_sample
);
    import fm_pkg::*;

    // newest operator output per voice
    // next operator of a voice is issued 16 slots later,
    // well after this write, so the read is always fresh
    logic signed [SAMPLE_W-1:0] r_mod [NUM_VOICES];

    // write side
    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int v = 0; v < NUM_VOICES; v++) begin
                r_mod[v] <= '0;
            end
        end else if (i_out.valid) begin
            // every operator writes, op 5 output is simply never read
            // since op 0 takes no modulation
            r_mod[i_out.voice] <= i_out.sample;
        end
    end

    // read side
    // combinational, feeds the operator's first stage add
    assign o_rd_sample = r_mod[i_rd_voice];

endmodule

//--- fm_operator.sv
`timescale 1ns/1ps

module fm_operator (
    input  logic                i_Clock,
    input  logic                i_rst_n,
    input  fm_pkg::fm_slot_t    i_slot,
    output logic [3:0]          o_mod_voice,
    input  logic signed [15:0]  i_mod_sample,
    output fm_pkg::fm_out_t     o_out
);
    import fm_pkg::*;

    // slot identity that rides along the pipeline
    typedef struct packed {
        logic               valid;
        logic [OP_W-1:0]    op;
        logic [VOICE_W-1:0] voice;
    } tag_t;

    // quarter-wave sine table, mirrored for the other quadrants
    logic signed [SAMPLE_W-1:0] sine_rom [SINE_ENTRIES];

    initial begin
        $readmemh("sine_quarter.mem", sine_rom);
    end

    // stage tags, index 0 is stage 1
    tag_t r_tag [5];

    // level follows the data through stages 1 to 3
    logic [LEVEL_W-1:0] r_level [3];

    logic [PHASE_W-1:0]                w_mod_phase;
    logic [PHASE_W-1:0]                w_phase_eff;
    logic [SINE_ADDR_W+1:0]            r_index;
    logic [SINE_ADDR_W-1:0]            r_addr;
    logic                              r_neg;
    logic signed [SAMPLE_W-1:0]        r_sine;
    logic signed [SAMPLE_W+LEVEL_W:0]  r_prod;
    logic signed [SAMPLE_W-1:0]        r_sample;

    // modulation comes from the previous operator of this voice
    assign o_mod_voice = i_slot.voice;

    // operator 0 heads the chain and is unmodulated
    assign w_mod_phase = (i_slot.op == '0) ? '0 : i_mod_sample;
    assign w_phase_eff = i_slot.phase + w_mod_phase;

    // tags
    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int k = 0; k < 5; k++) begin
                r_tag[k] <= '0;
            end
        end else begin
            r_tag[0] <= '{valid: i_slot.valid, op: i_slot.op, voice: i_slot.voice};
            for (int k = 1; k < 5; k++) begin
                r_tag[k] <= r_tag[k-1];
            end
        end
    end

    // datapath
    always_ff @(posedge i_Clock) begin
        // stage 1, phase plus modulation, only the top 8 bits index the table
        r_index    <= w_phase_eff[PHASE_W-1 -: SINE_ADDR_W+2];
        r_level[0] <= i_slot.level;

        // stage 2, quadrant split
        // odd quadrants run the table backwards, T[63-j] is ~j
        r_addr     <= r_index[SINE_ADDR_W] ? ~r_index[SINE_ADDR_W-1:0]
                                           : r_index[SINE_ADDR_W-1:0];
        // lower half-wave is negative
        r_neg      <= r_index[SINE_ADDR_W+1];
        r_level[1] <= r_level[0];

        // stage 3, table read with sign applied
        r_sine     <= r_neg ? -sine_rom[r_addr] : sine_rom[r_addr];
        r_level[2] <= r_level[1];

        // stage 4, level is unsigned so widen with a zero sign bit
        r_prod <= r_sine * $signed({1'b0, r_level[2]});

        // stage 5, Q0.16 scale is an arithmetic shift by 16
        r_sample <= r_prod[SAMPLE_W+LEVEL_W-1:LEVEL_W];
    end

    always_comb begin
        o_out.valid  = r_tag[4].valid;
        o_out.op     = r_tag[4].op;
        o_out.voice  = r_tag[4].voice;
        o_out.sample = r_sample;
    end

    // sequencer must never issue an operator beyond the chain
    a_op_range: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        i_slot.valid |-> (i_slot.op < OP_W'(NUM_OPS)))
        else $error("operator index %0d out of range", i_slot.op);

endmodule

//--- fm_slot_sequencer.sv
`timescale 1ns/1ps

module fm_slot_sequencer (
    input  logic             i_Clock,
    input  logic             i_rst_n,
    input  logic             i_run,
    input  fm_pkg::fm_cfg_t  i_cfg,
    output fm_pkg::fm_slot_t o_slot
);
    import fm_pkg::*;

    // current slot, op in the top bits and voice in the bottom bits
    logic [SLOT_W-1:0] r_slot_cnt;
    logic              w_wrap;

    // per-slot configuration
    logic [PHASE_W-1:0] r_step [NUM_SLOTS];
    logic [LEVEL_W-1:0] r_level [NUM_SLOTS];

    // per-slot phase accumulators
    logic [PHASE_W-1:0] r_phase_acc [NUM_SLOTS];

    assign w_wrap = (r_slot_cnt == SLOT_W'(NUM_SLOTS - 1));

    // configuration store
    // a write lands before the next issue of that slot
    always_ff @(posedge i_Clock) begin
        if (i_cfg.we) begin
            r_step[i_cfg.slot]  <= i_cfg.step;
            r_level[i_cfg.slot] <= i_cfg.level;
        end
    end

    always_ff @(posedge i_Clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_slot_cnt <= '0;
            o_slot     <= '0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                r_phase_acc[s] <= '0;
            end
        end else if (!i_run) begin
            // stopped, restart the frame and all phases from zero
            r_slot_cnt   <= '0;
            o_slot.valid <= 1'b0;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                r_phase_acc[s] <= '0;
            end
        end else begin
            // issue the slot with its phase before the step is added
            o_slot.valid <= 1'b1;
            o_slot.op    <= r_slot_cnt[SLOT_W-1:VOICE_W];
            o_slot.voice <= r_slot_cnt[VOICE_W-1:0];
            o_slot.phase <= r_phase_acc[r_slot_cnt];
            o_slot.level <= r_level[r_slot_cnt];

            // advance this slot for the next frame
            r_phase_acc[r_slot_cnt] <= r_phase_acc[r_slot_cnt] + r_step[r_slot_cnt];

            // 96 slots per frame, no power of two so wrap explicitly
            r_slot_cnt <= w_wrap ? '0 : r_slot_cnt + 1'b1;
        end
    end

    // slot counter stays inside the frame
    a_cnt_range: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        r_slot_cnt < SLOT_W'(NUM_SLOTS))
        else $error("slot counter out of range");

    // config writes must target an existing slot
    a_cfg_slot: assert property (@(posedge i_Clock) disable iff (!i_rst_n)
        i_cfg.we |-> (i_cfg.slot < SLOT_W'(NUM_SLOTS)))
        else $error("config write to slot %0d", i_cfg.slot);

endmodule

//--- fm_pkg.sv
package fm_pkg;

    // frame geometry
    localparam int NUM_VOICES   = 16;
    localparam int NUM_OPS      = 6;
    // one slot per clock, slot = op * 16 + voice
    localparam int NUM_SLOTS    = NUM_VOICES * NUM_OPS;
    // only operator 5 reaches the mixer
    localparam int CARRIER_OP   = 5;
    localparam int SINE_ENTRIES = 64;

    // field widths
    localparam int SLOT_W      = 7;
    localparam int OP_W        = 3;
    localparam int VOICE_W     = 4;
    localparam int PHASE_W     = 16;
    localparam int LEVEL_W     = 16;
    localparam int SAMPLE_W    = 16;
    localparam int SINE_ADDR_W = 6;

    // mixer sum width and output shift, 16 voices need 4 extra bits
    localparam int MIX_W     = 20;
    localparam int MIX_SHIFT = 4;

    // configuration write for one slot
    typedef struct packed {
        logic               we;
        logic [SLOT_W-1:0]  slot;
        logic [PHASE_W-1:0] step;
        // Q0.16 fraction
        logic [LEVEL_W-1:0] level;
    } fm_cfg_t;

    // slot issued by the sequencer
    typedef struct packed {
        logic               valid;
        logic [OP_W-1:0]    op;
        logic [VOICE_W-1:0] voice;
        logic [PHASE_W-1:0] phase;
        logic [LEVEL_W-1:0] level;
    } fm_slot_t;

    // operator result
    typedef struct packed {
        logic                       valid;
        logic [OP_W-1:0]            op;
        logic [VOICE_W-1:0]         voice;
        logic signed [SAMPLE_W-1:0] sample;
    } fm_out_t;

endpackage
